// File: logic/attn_macros.svh
// Geometry and bus width defines, pulled in by every package and module that sizes a vector
`ifndef ATTN_MACROS_SVH
`define ATTN_MACROS_SVH

// Processing elements, which is also the number of query rows held in one bank
`define NUM_PES 4

// Elements per vector, chosen so that one vector fills a single bus word
`define VEC_LEN 4

// Width of one signed vector element
`define ELEM_W 8

// Wishbone data width and word address width
`define WB_DW 32
`define WB_AW 4

`endif

// File: logic/attn_types_pkg.sv
// Data types shared by the buffer, the score engine and the bus slave for vectors and scores
`include "attn_macros.svh"

package attn_types_pkg;

    // One signed query or key element
    typedef logic signed [`ELEM_W-1:0] q_elem_t;

    // A whole vector packed into one bus word
    // Element 0 sits in the low byte so that byte lanes map straight onto elements
    typedef q_elem_t [`VEC_LEN-1:0] q_vector_t;

    // Width of one dot product
    // A 16-bit product summed VEC_LEN times needs 18 bits, so 20 leaves headroom
    localparam int SCORE_W = 20;

    // Signed dot product of one query row against the key
    typedef logic signed [SCORE_W-1:0] score_t;

    // Signed product of two elements before accumulation
    typedef logic signed [2*`ELEM_W-1:0] q_prod_t;

endpackage

// File: logic/attn_bus_pkg.sv
// Register map of the Wishbone slave and state encoding of the score engine FSM
`include "attn_macros.svh"

package attn_bus_pkg;

    // Word addresses seen by the host
    // Scores follow REG_SCORE0, one address per PE
    typedef enum logic [`WB_AW-1:0] {
        REG_Q_DATA = 4'd0,
        REG_K_VEC  = 4'd1,
        REG_STATUS = 4'd2,
        REG_SCORE0 = 4'd4
    } wb_reg_e;

    // Score engine FSM states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_ACCUM,
        ENG_STORE
    } eng_state_e;

endpackage

// File: logic/q_loader.sv
// Wishbone classic slave that pushes query rows into the buffer, holds the key and reads scores
`timescale 1ns/1ns
`include "attn_macros.svh"

module q_loader (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`WB_AW-1:0]         wb_adr,
    input  logic [`WB_DW-1:0]         wb_dat_w,
    output logic [`WB_DW-1:0]         wb_dat_r,
    output logic                      wb_ack,
    input  logic                      sram_ready,
    input  attn_types_pkg::score_t    scores [`NUM_PES],
    input  logic [7:0]                batch_count,
    output logic                      write_enable,
    output attn_types_pkg::q_vector_t write_data,
    output attn_types_pkg::q_vector_t k_vector
);
    import attn_bus_pkg::*;

    // A new request is one not already being acknowledged this cycle
    logic req;
    logic q_write;
    logic k_write;
    logic ack_next;
    logic [`WB_DW-1:0] read_word;

    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign q_write = req && wb_we && (wb_adr == REG_Q_DATA);
    assign k_write = req && wb_we && (wb_adr == REG_K_VEC);

    // Query pushes are the only back-pressure point
    // Such a write stalls, unacknowledged, until the fill bank has room
    assign ack_next = req && (!q_write || sram_ready);

    // Read mux for the host where unmapped and write-only addresses read zero
    always_comb begin
        read_word = '0;
        case (wb_adr)
            REG_K_VEC: read_word = k_vector;
            REG_STATUS: read_word = `WB_DW'({batch_count, 7'b0, sram_ready});
            default: begin
                for (int p = 0; p < `NUM_PES; p++) begin
                    // The size cast sign-extends the signed score to the bus width
                    if (wb_adr == REG_SCORE0 + `WB_AW'(p)) begin
                        read_word = `WB_DW'(scores[p]);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack       <= 1'b0;
            write_enable <= 1'b0;
            k_vector     <= '0;
        end else begin
            wb_ack <= ack_next;
            // The push and its ack leave in the same cycle
            // sram_ready cannot fall in between since no other write is in flight
            write_enable <= q_write && sram_ready;
            if (k_write) begin
                k_vector <= wb_dat_w;
            end
        end
    end

    // Write data and read data trail the bus by one cycle and go out with write_enable and wb_ack
    always_ff @(posedge clock) begin
        write_data <= wb_dat_w;
        wb_dat_r   <= read_word;
    end

    // Each access gets exactly one ack cycle, even when the master holds its request
    ack_single_cycle: assert property (
        @(posedge clock) disable iff (reset) wb_ack |=> !wb_ack
    );

endmodule

// File: logic/q_sram.sv
// Two-bank query buffer where one bank fills from the bus while the other feeds the PEs
`timescale 1ns/1ns
`include "attn_macros.svh"

module q_sram #(
    parameter int NUM_ROWS = `NUM_PES
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_enable,
    input  attn_types_pkg::q_vector_t write_data,
    input  logic                      read_enable,
    output logic                      sram_ready,
    output logic                      read_data_valid,
    output attn_types_pkg::q_vector_t read_data [NUM_ROWS]
);
    import attn_types_pkg::*;

    // Both banks are indexed by bank number and then by row
    q_vector_t bank [2][NUM_ROWS];

    // A bank is full once all NUM_ROWS rows have been written
    logic full [2];

    // Bank taking new rows and bank presented to the engine
    logic fill_bank;
    logic read_bank;

    // Next row to write in the fill bank
    logic [$clog2(NUM_ROWS)-1:0] wr_idx;

    // Room for a row unless the fill bank is still waiting to be consumed
    assign sram_ready      = !full[fill_bank];
    assign read_data_valid = full[read_bank];

    // The read bank is shown as is, so rows only move when read_enable swaps banks
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            read_data[r] = bank[read_bank][r];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            full[0]   <= 1'b0;
            full[1]   <= 1'b0;
            fill_bank <= 1'b0;
            read_bank <= 1'b0;
            wr_idx    <= '0;
        end else begin
            if (write_enable) begin
                if (wr_idx == NUM_ROWS - 1) begin
                    // Last row closes the bank and filling moves to the other one
                    full[fill_bank] <= 1'b1;
                    fill_bank       <= !fill_bank;
                    wr_idx          <= '0;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
            // A release always targets the other bank from any write in the same cycle
            if (read_enable) begin
                full[read_bank] <= 1'b0;
                read_bank       <= !read_bank;
            end
        end
    end

    // Row storage is wiped when the engine hands a bank back
    always_ff @(posedge clock) begin
        if (write_enable) begin
            bank[fill_bank][wr_idx] <= write_data;
        end
        if (read_enable) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                bank[read_bank][r] <= '0;
            end
        end
    end

    // The loader must only push when there is room
    write_needs_room: assert property (
        @(posedge clock) disable iff (reset) write_enable |-> sram_ready
    );

    // The engine must only release a bank that it was given
    read_needs_valid: assert property (
        @(posedge clock) disable iff (reset) read_enable |-> read_data_valid
    );

endmodule

// File: logic/score_engine.sv
// Parallel dot-product engine that scores a full bank of query rows against the key
`timescale 1ns/1ns
`include "attn_macros.svh"

module score_engine #(
    parameter int NUM_PES = `NUM_PES
) (
    input  logic                      clock,
    input  logic                      reset,
    input  attn_types_pkg::q_vector_t q_rows [NUM_PES],
    input  logic                      rows_valid,
    input  attn_types_pkg::q_vector_t k_vector,
    output logic                      read_enable,
    output attn_types_pkg::score_t    scores [NUM_PES],
    output logic [7:0]                batch_count
);
    import attn_types_pkg::*;
    import attn_bus_pkg::*;

    eng_state_e state;

    // Index of the element multiplied this cycle as the engine steps across the vector
    logic [$clog2(`VEC_LEN)-1:0] idx;

    // Per-PE product of the current element pair and its running sum
    q_prod_t prod [NUM_PES];
    score_t  acc  [NUM_PES];

    always_comb begin
        for (int p = 0; p < NUM_PES; p++) begin
            prod[p] = q_rows[p][idx] * k_vector[idx];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ENG_IDLE;
            idx         <= '0;
            read_enable <= 1'b0;
            batch_count <= '0;
            for (int p = 0; p < NUM_PES; p++) begin
                scores[p] <= '0;
            end
        end else begin
            case (state)
                ENG_IDLE: begin
                    idx <= '0;
                    if (rows_valid) begin
                        state <= ENG_ACCUM;
                    end
                end
                ENG_ACCUM: begin
                    idx <= idx + 1'b1;
                    // On the last element the release is raised for the store cycle
                    if (idx == $bits(idx)'(`VEC_LEN - 1)) begin
                        state       <= ENG_STORE;
                        read_enable <= 1'b1;
                    end
                end
                ENG_STORE: begin
                    // All scores appear together with the new count
                    for (int p = 0; p < NUM_PES; p++) begin
                        scores[p] <= acc[p];
                    end
                    batch_count <= batch_count + 1'b1;
                    read_enable <= 1'b0;
                    state       <= ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Accumulators clear while idle and add one product per element while accumulating
    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_PES; p++) begin
            if (state == ENG_IDLE) begin
                acc[p] <= '0;
            end else if (state == ENG_ACCUM) begin
                acc[p] <= acc[p] + prod[p];
            end
        end
    end

    // The bank is handed back only in the store cycle
    release_in_store: assert property (
        @(posedge clock) disable iff (reset) read_enable |-> state == ENG_STORE
    );

endmodule

// File: logic/attn_front_top.sv
// Top level of the query front end joining the bus slave, the query buffer and the score engine
`timescale 1ns/1ns
`include "attn_macros.svh"

module attn_front_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [`WB_AW-1:0] wb_adr,
    input  logic [`WB_DW-1:0] wb_dat_w,
    output logic [`WB_DW-1:0] wb_dat_r,
    output logic              wb_ack
);
    import attn_types_pkg::*;

    // Loader to buffer
    logic      sram_ready;
    logic      write_enable;
    q_vector_t write_data;

    // Buffer to engine
    logic      read_enable;
    logic      read_data_valid;
    q_vector_t read_data [`NUM_PES];

    // Engine back to the loader, and the key forward to the engine
    score_t     scores [`NUM_PES];
    logic [7:0] batch_count;
    q_vector_t  k_vector;

    q_loader u_loader (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sram_ready(sram_ready), .scores(scores), .batch_count(batch_count),
        .write_enable(write_enable), .write_data(write_data), .k_vector(k_vector)
    );

    q_sram #(.NUM_ROWS(`NUM_PES)) u_sram (
        .clock(clock), .reset(reset),
        .write_enable(write_enable), .write_data(write_data), .read_enable(read_enable),
        .sram_ready(sram_ready), .read_data_valid(read_data_valid), .read_data(read_data)
    );

    score_engine #(.NUM_PES(`NUM_PES)) u_engine (
        .clock(clock), .reset(reset),
        .q_rows(read_data), .rows_valid(read_data_valid), .k_vector(k_vector),
        .read_enable(read_enable), .scores(scores), .batch_count(batch_count)
    );

endmodule

// File: dv/tb_attn_front.sv
// Directed testbench for the query front end, driving Wishbone traffic and checking scores
`timescale 1ns/1ns
`include "attn_macros.svh"

module tb_attn_front;
    import attn_bus_pkg::*;

    // Falling edges allowed for one ack, and status polls allowed for one batch
    localparam int ACK_LIMIT  = 200;
    localparam int POLL_LIMIT = 100;

    logic              clock;
    logic              reset;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [`WB_AW-1:0] wb_adr;
    logic [`WB_DW-1:0] wb_dat_w;
    logic [`WB_DW-1:0] wb_dat_r;
    logic              wb_ack;

    // Seed for every random element and key
    integer seed;

    // Batch count that STATUS should show once the pushed batches are scored
    int batches_done;

    // Rows of up to three batches, the current key and the model's scores
    logic [`WB_DW-1:0] rows [3][`NUM_PES];
    logic [`WB_DW-1:0] key;
    logic [`WB_DW-1:0] expected [`NUM_PES];

    attn_front_top UUT (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always #5 clock = ~clock;

    // Ends the run right after the first error has been described
    task automatic stop_failed();
        $display("sim failed");
        $fatal(1, "first error ends the run");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expect_val);
        if (actual !== expect_val) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expect_val);
            stop_failed();
        end
    endtask

    // Ack is sampled on the falling edge, half a cycle after the slave registered it
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!wb_ack && cycles < ACK_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!wb_ack) begin
            $display("no ack from the bus slave within %0d cycles at address %0d",
                     ACK_LIMIT, wb_adr);
            stop_failed();
        end
    endtask

    task automatic wb_write(input logic [`WB_AW-1:0] addr, input logic [`WB_DW-1:0] data);
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        // A query push may stall here while both banks are busy
        wait_ack();
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`WB_AW-1:0] addr, output logic [`WB_DW-1:0] data);
        @(posedge clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wait_ack();
        // Read data is registered together with the ack
        data = wb_dat_r;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Polls STATUS until bits 15:8 show the wanted batch count
    task automatic wait_batches(input int target);
        logic [31:0] status;
        int polls;
        polls = 0;
        wb_read(REG_STATUS, status);
        while (status[15:8] != 8'(target) && polls < POLL_LIMIT) begin
            wb_read(REG_STATUS, status);
            polls++;
        end
        if (status[15:8] != 8'(target)) begin
            $display("batch count stuck at %0d while waiting for %0d", status[15:8], target);
            stop_failed();
        end
    endtask

    function automatic logic [`WB_AW-1:0] score_addr(input int p);
        return `WB_AW'(int'(REG_SCORE0) + p);
    endfunction

    // Model of one batch that treats each element as a signed byte with element 0 in the low byte
    task automatic compute_expected(input int b);
        int sum;
        for (int p = 0; p < `NUM_PES; p++) begin
            sum = 0;
            for (int e = 0; e < `VEC_LEN; e++) begin
                sum += int'($signed(rows[b][p][`ELEM_W*e +: `ELEM_W]))
                     * int'($signed(key[`ELEM_W*e +: `ELEM_W]));
            end
            // The bus shows the score sign-extended to a full word
            expected[p] = sum;
        end
    endtask

    task automatic check_scores();
        logic [31:0] data;
        for (int p = 0; p < `NUM_PES; p++) begin
            wb_read(score_addr(p), data);
            check($sformatf("score%0d", p), data, expected[p]);
        end
    endtask

    task automatic push_batch(input int b);
        for (int p = 0; p < `NUM_PES; p++) begin
            wb_write(REG_Q_DATA, rows[b][p]);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        wb_read(REG_STATUS, data);
        check("status", data, 32'h0000_0001);
        for (int p = 0; p < `NUM_PES; p++) begin
            wb_read(score_addr(p), data);
            check($sformatf("score%0d", p), data, 32'h0);
        end
    endtask

    task automatic test_key_register();
        logic [31:0] data;
        wb_write(REG_K_VEC, 32'hA55A_7F80);
        wb_read(REG_K_VEC, data);
        check("k_vector", data, 32'hA55A_7F80);
    endtask

    task automatic test_single_batch();
        // Key elements are -128, 127, -128 and 1 from the low byte up
        key = 32'h0180_7F80;
        // Row 0 hits -128 x -128 and -128 x 127, row 1 hits 127 x -128
        rows[0][0] = 32'h8080_8080;
        rows[0][1] = 32'h7F7F_7F7F;
        for (int p = 2; p < `NUM_PES; p++) begin
            rows[0][p] = $random(seed);
        end
        wb_write(REG_K_VEC, key);
        push_batch(0);
        batches_done++;
        wait_batches(batches_done);
        compute_expected(0);
        check_scores();
    endtask

    task automatic test_ping_pong();
        key = $random(seed);
        for (int b = 0; b < 3; b++) begin
            for (int p = 0; p < `NUM_PES; p++) begin
                rows[b][p] = $random(seed);
            end
        end
        wb_write(REG_K_VEC, key);
        // First batch plus one row of the second, so the second stays pending
        for (int i = 0; i <= `NUM_PES; i++) begin
            wb_write(REG_Q_DATA, rows[i / `NUM_PES][i % `NUM_PES]);
        end
        wait_batches(batches_done + 1);
        compute_expected(0);
        check_scores();
        // The remaining rows fill the second bank and then the first bank again
        for (int i = `NUM_PES + 1; i < 3 * `NUM_PES; i++) begin
            wb_write(REG_Q_DATA, rows[i / `NUM_PES][i % `NUM_PES]);
        end
        batches_done += 3;
        wait_batches(batches_done);
        compute_expected(2);
        check_scores();
    endtask

    task automatic test_key_change();
        key = $random(seed);
        wb_write(REG_K_VEC, key);
        // Stored scores of the last batch do not follow the new key
        check_scores();
        for (int p = 0; p < `NUM_PES; p++) begin
            rows[0][p] = $random(seed);
        end
        push_batch(0);
        batches_done++;
        wait_batches(batches_done);
        compute_expected(0);
        check_scores();
    endtask

    task automatic test_random_batches();
        logic [31:0] data;
        for (int n = 0; n < 5; n++) begin
            key = $random(seed);
            for (int p = 0; p < `NUM_PES; p++) begin
                rows[0][p] = $random(seed);
            end
            wb_write(REG_K_VEC, key);
            push_batch(0);
            batches_done++;
            wait_batches(batches_done);
            compute_expected(0);
            check_scores();
            // Engine idle and nothing pending, so the buffer takes rows again
            wb_read(REG_STATUS, data);
            check("status", data, {16'h0, 8'(batches_done), 8'h01});
        end
    endtask

    initial begin
        seed         = 26;
        batches_done = 0;
        clock        = 1'b0;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        test_reset_state();
        test_key_register();
        test_single_batch();
        test_ping_pong();
        test_key_change();
        test_random_batches();
        $display("sim passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/attn_types_pkg.sv
logic/attn_bus_pkg.sv
logic/q_loader.sv
logic/q_sram.sv
logic/score_engine.sv
logic/attn_front_top.sv
dv/tb_attn_front.sv

// File: Makefile
# Verilator build and run of the query front end testbench

TOP  = tb_attn_front
SRCS = $(shell grep -v '^+' vlog.f)

all: run

# The simulator binary is rebuilt only when a source, a header or the file list changes
obj_dir/V%: vlog.f $(SRCS) logic/attn_macros.svh
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		-f vlog.f --top-module $* -o V$*

# The run passes only when the log holds the pass message
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
